/* list.f */
logic/dap_pkg.sv
logic/dap_buf.sv
logic/dap_resp_pack.sv
logic/apb_ap.sv
logic/mem_ap.sv
logic/dap.sv
tb/tb_slaves.sv
tb/tb_dap.sv

/* logic/apb_ap.sv */
`timescale 1ns/100ps

module apb_ap (
    input  logic              wclk,
    input  logic              rrstn_sync,
    input  logic              ap_upd,
    input  dap_pkg::ap_req_t  ap_req,
    output dap_pkg::ap_rsp_t  ap_rsp,
    input  logic              deviceen,
    output dap_pkg::apb_req_t apb_m,
    input  dap_pkg::apb_rsp_t apb_s
);

    typedef enum logic [1:0] {
        st_idle,
        st_setup,
        st_access
    } state_t;

    state_t      state;
    logic [31:0] tar;
    logic [31:0] rdata;
    logic        slverr;
    logic        pwrite;
    logic [31:0] pwdata;
    logic        tar_upd;
    logic        drw_upd;

    assign tar_upd = ap_upd && ap_req.addr == dap_pkg::REG_TAR;
    assign drw_upd = ap_upd && ap_req.addr == dap_pkg::REG_DRW;

    always_ff @(posedge wclk or negedge rrstn_sync) begin
        if (!rrstn_sync) begin
            state  <= st_idle;
            tar    <= '0;
            rdata  <= '0;
            slverr <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (drw_upd && deviceen) begin
                        state  <= st_setup;
                        slverr <= 1'b0;
                    end else if (drw_upd) begin
                        // device disabled, fail at once
                        slverr <= 1'b1;
                    end
                end
                st_setup: begin
                    state <= st_access;
                end
                st_access: begin
                    if (apb_s.pready) begin
                        state  <= st_idle;
                        slverr <= apb_s.pslverr;
                        if (!pwrite) begin
                            rdata <= apb_s.prdata;
                        end
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
            if (tar_upd) begin
                if (ap_req.rnw) begin
                    rdata <= tar;
                end else begin
                    tar <= ap_req.wdata;
                end
            end
        end
    end

    always_ff @(posedge wclk) begin
        if (drw_upd) begin
            pwrite <= !ap_req.rnw;
            pwdata <= ap_req.wdata;
        end
    end

    assign apb_m.psel    = state != st_idle;
    assign apb_m.penable = state == st_access;
    assign apb_m.pwrite  = pwrite;
    assign apb_m.paddr   = tar;
    assign apb_m.pwdata  = pwdata;

    assign ap_rsp.rdata  = rdata;
    assign ap_rsp.slverr = slverr;
    assign ap_rsp.busy   = state != st_idle;

    a_upd_idle: assert property (@(posedge wclk) disable iff (!rrstn_sync)
        ap_upd |-> state == st_idle)
        else $error("apb_ap: update while busy");

    // a stalled access keeps its address and data
    a_stall_hold: assert property (@(posedge wclk) disable iff (!rrstn_sync)
        apb_m.penable && !apb_s.pready |=> $stable(apb_m.paddr) && $stable(apb_m.pwdata))
        else $error("apb_ap: transfer changed during wait state");

endmodule

/* logic/dap.sv */
`timescale 1ns/100ps

module dap (
    input  logic              wclk,
    input  logic              rrstn_sync,
    input  logic              ap_upd,
    input  dap_pkg::ap_req_t  ap_req,
    output dap_pkg::ap_rsp_t  ap_rsp,
    input  logic              apb_deviceen,
    input  logic              mem_deviceen,
    input  logic              wbuf_push,
    input  logic [31:0]       wbuf_wdata,
    input  logic              rbuf_pop,
    output logic [31:0]       rbuf_rdata,
    input  logic              rresp_pop,
    output logic [31:0]       rresp_rdata,
    output dap_pkg::apb_req_t apb_m,
    input  dap_pkg::apb_rsp_t apb_s,
    output dap_pkg::mem_req_t mem_m,
    input  dap_pkg::mem_rsp_t mem_s
);

    logic [7:0]               sel_q;
    logic                     apb_upd;
    logic                     mem_upd;
    dap_pkg::ap_rsp_t         apb_rsp;
    dap_pkg::ap_rsp_t         mem_rsp;
    logic                     wbuf_pop;
    logic [31:0]              wbuf_rdata;
    logic [dap_pkg::BUF_AW:0] wbuf_rsize;
    logic                     rbuf_push;
    logic [31:0]              rbuf_wdata;
    logic [dap_pkg::BUF_AW:0] rbuf_rsize;
    logic                     rresp_push;
    logic [1:0]               rresp_wresp;

    always_ff @(posedge wclk or negedge rrstn_sync) begin
        if (!rrstn_sync) begin
            sel_q <= dap_pkg::AP_SEL_APB;
        end else if (ap_upd) begin
            sel_q <= ap_req.sel;
        end
    end

    // routing uses the incoming code, the response mux the latched one
    assign apb_upd = ap_upd && ap_req.sel == dap_pkg::AP_SEL_APB;
    assign mem_upd = ap_upd && ap_req.sel == dap_pkg::AP_SEL_MEM;

    always_comb begin
        case (sel_q)
            dap_pkg::AP_SEL_APB: ap_rsp = apb_rsp;
            dap_pkg::AP_SEL_MEM: ap_rsp = mem_rsp;
            default:             ap_rsp = '0;
        endcase
    end

    apb_ap u_apb_ap (
        .wclk       (wclk),
        .rrstn_sync (rrstn_sync),
        .ap_upd     (apb_upd),
        .ap_req     (ap_req),
        .ap_rsp     (apb_rsp),
        .deviceen   (apb_deviceen),
        .apb_m      (apb_m),
        .apb_s      (apb_s)
    );

    mem_ap u_mem_ap (
        .wclk        (wclk),
        .rrstn_sync  (rrstn_sync),
        .ap_upd      (mem_upd),
        .ap_req      (ap_req),
        .ap_rsp      (mem_rsp),
        .deviceen    (mem_deviceen),
        .wbuf_pop    (wbuf_pop),
        .wbuf_rdata  (wbuf_rdata),
        .rbuf_push   (rbuf_push),
        .rbuf_wdata  (rbuf_wdata),
        .rresp_push  (rresp_push),
        .rresp_wresp (rresp_wresp),
        .mem_m       (mem_m),
        .mem_s       (mem_s)
    );

    dap_buf #(.payload_t(dap_pkg::word_t)) u_wbuf (
        .wclk       (wclk),
        .rrstn_sync (rrstn_sync),
        .push       (wbuf_push),
        .wdata      (wbuf_wdata),
        .pop        (wbuf_pop),
        .rdata      (wbuf_rdata),
        .rsize      (wbuf_rsize)
    );

    dap_buf #(.payload_t(dap_pkg::word_t)) u_rbuf (
        .wclk       (wclk),
        .rrstn_sync (rrstn_sync),
        .push       (rbuf_push),
        .wdata      (rbuf_wdata),
        .pop        (rbuf_pop),
        .rdata      (rbuf_rdata),
        .rsize      (rbuf_rsize)
    );

    dap_resp_pack u_rresp (
        .wclk       (wclk),
        .rrstn_sync (rrstn_sync),
        .push       (rresp_push),
        .wresp      (rresp_wresp),
        .pop        (rresp_pop),
        .rdata      (rresp_rdata)
    );

    // a burst write needs its data already buffered
    a_wbuf_filled: assert property (@(posedge wclk) disable iff (!rrstn_sync)
        mem_upd && ap_req.addr == dap_pkg::REG_BWR |->
            wbuf_rsize >= {1'b0, ap_req.wdata[5:0]})
        else $error("dap: burst write longer than buffered data");

    // and a burst read needs room for all its beats
    a_rbuf_room: assert property (@(posedge wclk) disable iff (!rrstn_sync)
        mem_upd && ap_req.addr == dap_pkg::REG_BRD |->
            {1'b0, rbuf_rsize} + {2'b0, ap_req.wdata[5:0]} <= 8'(dap_pkg::BUF_DEPTH))
        else $error("dap: burst read would overflow read buffer");

endmodule

/* logic/dap_buf.sv */
`timescale 1ns/100ps

module dap_buf #(
    parameter type payload_t = dap_pkg::word_t
) (
    input  logic                     wclk,
    input  logic                     rrstn_sync,
    input  logic                     push,
    input  payload_t                 wdata,
    input  logic                     pop,
    output payload_t                 rdata,
    output logic [dap_pkg::BUF_AW:0] rsize
);

    payload_t                 store [dap_pkg::BUF_DEPTH];
    logic [dap_pkg::BUF_AW:0] wptr;
    logic [dap_pkg::BUF_AW:0] rptr;

    // top pointer bit separates full from empty
    assign rsize = wptr - rptr;
    assign rdata = store[rptr[dap_pkg::BUF_AW-1:0]];

    always_ff @(posedge wclk or negedge rrstn_sync) begin
        if (!rrstn_sync) begin
            wptr <= '0;
            rptr <= '0;
        end else begin
            if (push) begin
                wptr <= wptr + 1'b1;
            end
            if (pop) begin
                rptr <= rptr + 1'b1;
            end
        end
    end

    always_ff @(posedge wclk) begin
        if (push) begin
            store[wptr[dap_pkg::BUF_AW-1:0]] <= wdata;
        end
    end

    a_no_overflow: assert property (@(posedge wclk) disable iff (!rrstn_sync)
        push |-> int'(rsize) != dap_pkg::BUF_DEPTH)
        else $error("dap_buf: push while full");

    a_no_underflow: assert property (@(posedge wclk) disable iff (!rrstn_sync)
        pop |-> rsize != '0)
        else $error("dap_buf: pop while empty");

endmodule

/* logic/dap_pkg.sv */
package dap_pkg;

    // access port select codes
    localparam logic [7:0] AP_SEL_APB = 8'h00;
    localparam logic [7:0] AP_SEL_MEM = 8'h01;

    localparam int BUF_DEPTH = 64;
    localparam int BUF_AW    = 6;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // register word addresses
    localparam logic [5:0] REG_TAR = 6'd0;
    localparam logic [5:0] REG_DRW = 6'd3;
    localparam logic [5:0] REG_BWR = 6'd4;
    localparam logic [5:0] REG_BRD = 6'd5;

    // slaves answer with an error at or above this address
    localparam logic [31:0] ERR_BASE = 32'hFFFF_0000;

    typedef logic [31:0] word_t;

    typedef struct packed {
        logic [7:0] sel;
        logic [5:0] addr;
        logic       rnw;
        word_t      wdata;
    } ap_req_t;

    typedef struct packed {
        word_t rdata;
        logic  slverr;
        logic  busy;
    } ap_rsp_t;

    typedef struct packed {
        logic  psel;
        logic  penable;
        logic  pwrite;
        word_t paddr;
        word_t pwdata;
    } apb_req_t;

    typedef struct packed {
        logic  pready;
        word_t prdata;
        logic  pslverr;
    } apb_rsp_t;

    typedef struct packed {
        logic  valid;
        logic  we;
        word_t addr;
        word_t wdata;
    } mem_req_t;

    typedef struct packed {
        logic  rvalid;
        word_t rdata;
        logic  err;
    } mem_rsp_t;

endpackage

/* logic/dap_resp_pack.sv */
`timescale 1ns/100ps

module dap_resp_pack (
    input  logic        wclk,
    input  logic        rrstn_sync,
    input  logic        push,
    input  logic [1:0]  wresp,
    input  logic        pop,
    output logic [31:0] rdata
);

    logic [127:0] store;
    logic [5:0]   wptr;
    logic [1:0]   rptr;

    // 16 fields of 2 bits per word, four words
    assign rdata = store[{rptr, 5'b0} +: 32];

    always_ff @(posedge wclk or negedge rrstn_sync) begin
        if (!rrstn_sync) begin
            store <= '0;
            wptr  <= '0;
            rptr  <= '0;
        end else begin
            if (push) begin
                store[{wptr, 1'b0} +: 2] <= wresp;
                wptr <= wptr + 6'd1;
            end
            if (pop) begin
                rptr <= rptr + 2'd1;
            end
        end
    end

endmodule

/* logic/mem_ap.sv */
`timescale 1ns/100ps

module mem_ap (
    input  logic              wclk,
    input  logic              rrstn_sync,
    input  logic              ap_upd,
    input  dap_pkg::ap_req_t  ap_req,
    output dap_pkg::ap_rsp_t  ap_rsp,
    input  logic              deviceen,
    output logic              wbuf_pop,
    input  logic [31:0]       wbuf_rdata,
    output logic              rbuf_push,
    output logic [31:0]       rbuf_wdata,
    output logic              rresp_push,
    output logic [1:0]        rresp_wresp,
    output dap_pkg::mem_req_t mem_m,
    input  dap_pkg::mem_rsp_t mem_s
);

    logic [31:0] tar;
    logic [31:0] cursor;
    logic [31:0] rdata;
    logic [5:0]  beat_cnt;
    logic [5:0]  rsp_cnt;
    logic [5:0]  nbeats;
    logic        we;
    logic        slverr;
    logic        masked_q;
    logic        burst_upd;
    logic        issue;
    logic        retire;
    logic        beat_err;

    assign nbeats    = ap_req.wdata[5:0];
    assign burst_upd = ap_upd && nbeats != 6'd0 &&
                       (ap_req.addr == dap_pkg::REG_BWR || ap_req.addr == dap_pkg::REG_BRD);
    assign issue     = beat_cnt != 6'd0;

    // masked beats never reach the bus, so they answer themselves
    assign retire    = mem_s.rvalid || masked_q;
    assign beat_err  = masked_q || mem_s.err;

    always_ff @(posedge wclk or negedge rrstn_sync) begin
        if (!rrstn_sync) begin
            tar      <= '0;
            rdata    <= '0;
            beat_cnt <= '0;
            rsp_cnt  <= '0;
            we       <= 1'b0;
            slverr   <= 1'b0;
            masked_q <= 1'b0;
        end else begin
            masked_q <= issue && !deviceen;
            if (burst_upd) begin
                beat_cnt <= nbeats;
                rsp_cnt  <= nbeats;
                we       <= ap_req.addr == dap_pkg::REG_BWR;
                slverr   <= 1'b0;
            end else begin
                if (issue) begin
                    beat_cnt <= beat_cnt - 6'd1;
                end
                if (retire) begin
                    rsp_cnt <= rsp_cnt - 6'd1;
                    slverr  <= slverr | beat_err;
                end
            end
            if (ap_upd && ap_req.addr == dap_pkg::REG_TAR) begin
                if (ap_req.rnw) begin
                    rdata <= tar;
                end else begin
                    tar <= ap_req.wdata;
                end
            end
        end
    end

    // beat address, word steps from TAR
    always_ff @(posedge wclk) begin
        if (burst_upd) begin
            cursor <= tar;
        end else if (issue) begin
            cursor <= cursor + 32'd4;
        end
    end

    assign mem_m.valid = issue && deviceen;
    assign mem_m.we    = we;
    assign mem_m.addr  = cursor;
    assign mem_m.wdata = wbuf_rdata;

    assign wbuf_pop    = issue && we;
    assign rbuf_push   = retire && !we;
    assign rbuf_wdata  = masked_q ? '0 : mem_s.rdata;
    assign rresp_push  = retire && !we;
    assign rresp_wresp = beat_err ? dap_pkg::RESP_SLVERR : dap_pkg::RESP_OKAY;

    assign ap_rsp.rdata  = rdata;
    assign ap_rsp.slverr = slverr;
    assign ap_rsp.busy   = rsp_cnt != 6'd0;

    a_upd_idle: assert property (@(posedge wclk) disable iff (!rrstn_sync)
        ap_upd |-> rsp_cnt == 6'd0)
        else $error("mem_ap: update while busy");

    // memory answers every beat on the next cycle
    a_rsp_next: assert property (@(posedge wclk) disable iff (!rrstn_sync)
        mem_m.valid |=> mem_s.rvalid)
        else $error("mem_ap: missing beat response");

endmodule

/* run.sh */
#!/usr/bin/env bash
# build the DAP testbench with Verilator and run it
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
        --top-module tb_dap -f list.f -o tb_dap_sim; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_dap_sim 2>&1)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Simulation completed successfully"; then
    exit 0
fi
exit 1

/* tb/tb_dap.sv */
`timescale 1ns/100ps

module tb_dap;

    logic              wclk;
    logic              rrstn_sync;
    logic              ap_upd;
    dap_pkg::ap_req_t  ap_req;
    dap_pkg::ap_rsp_t  ap_rsp;
    logic              apb_deviceen;
    logic              mem_deviceen;
    logic              wbuf_push;
    logic [31:0]       wbuf_wdata;
    logic              rbuf_pop;
    logic [31:0]       rbuf_rdata;
    logic              rresp_pop;
    logic [31:0]       rresp_rdata;
    dap_pkg::apb_req_t apb_m;
    dap_pkg::apb_rsp_t apb_s;
    dap_pkg::mem_req_t mem_m;
    dap_pkg::mem_rsp_t mem_s;
    logic [1:0]        apb_wait;

    logic [31:0] lfsr;
    logic [7:0]  sel_track;
    logic [1:0]  resp_exp [64];
    logic [31:0] exp_words [$];
    int          resp_wr;
    int          errors;
    int          err_mark;
    int          tests;
    int          tests_failed;

    dap dut0 (.*);

    apb_slave_model u_apb (
        .wclk        (wclk),
        .rrstn_sync  (rrstn_sync),
        .wait_cycles (apb_wait),
        .req         (apb_m),
        .rsp         (apb_s)
    );

    mem_model u_mem (
        .wclk       (wclk),
        .rrstn_sync (rrstn_sync),
        .req        (mem_m),
        .rsp        (mem_s)
    );

    always #5 wclk = ~wclk;

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    task automatic mismatch(input string name, input logic [63:0] got, input logic [63:0] exp);
        $display("Mismatch %s: got %h expected %h", name, got, exp);
        errors++;
    endtask

    task automatic fault(input string what);
        $display("Error: %s", what);
        errors++;
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors == err_mark) begin
            $display("test %0d %s: pass", tests, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: FAIL with %0d errors", tests, name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    // one update strobe, returns on the following falling edge
    task automatic update(input logic [7:0] sel, input logic [5:0] addr, input logic rnw,
                          input logic [31:0] data);
        ap_upd = 1'b1;
        ap_req = '{sel: sel, addr: addr, rnw: rnw, wdata: data};
        @(negedge wclk);
        ap_upd    = 1'b0;
        sel_track = sel;
    endtask

    task automatic wait_idle(output int cycles);
        cycles = 0;
        while (ap_rsp.busy && cycles <= 200) begin
            cycles++;
            @(negedge wclk);
        end
        if (ap_rsp.busy) begin
            $display("Error: timeout, ap_rsp.busy stayed high");
            $display("Simulation failed");
            $finish;
        end
    endtask

    task automatic burst(input logic [5:0] reg_addr, input int n, input logic [31:0] tar);
        int cycles;
        update(dap_pkg::AP_SEL_MEM, dap_pkg::REG_TAR, 1'b0, tar);
        update(dap_pkg::AP_SEL_MEM, reg_addr, 1'b0, 32'(n));
        wait_idle(cycles);
        assert (cycles == n + 1) else mismatch("busy cycles", 64'(cycles), 64'(n + 1));
        if (reg_addr == dap_pkg::REG_BRD) begin
            for (int i = 0; i < n; i++) begin
                resp_exp[resp_wr % 64] =
                    (!mem_deviceen || tar + 32'(4 * i) >= dap_pkg::ERR_BASE) ?
                    dap_pkg::RESP_SLVERR : dap_pkg::RESP_OKAY;
                resp_wr++;
            end
        end
    endtask

    task automatic drain_reads(input int n, input bit check);
        logic [31:0] exp;
        for (int i = 0; i < n; i++) begin
            if (check) begin
                exp = exp_words.pop_front();
                assert (rbuf_rdata == exp) else mismatch("rbuf_rdata", 64'(rbuf_rdata), 64'(exp));
            end
            rbuf_pop = 1'b1;
            @(negedge wclk);
        end
        rbuf_pop = 1'b0;
    endtask

    a_disabled_no_psel: assert property (@(posedge wclk) disable iff (!rrstn_sync)
        !apb_deviceen |-> !apb_m.psel)
        else fault("APB transfer started while the APB device was disabled");

    a_disabled_no_valid: assert property (@(posedge wclk) disable iff (!rrstn_sync)
        !mem_deviceen |-> !mem_m.valid)
        else fault("memory beat issued while the memory device was disabled");

    a_apb_busy: assert property (@(posedge wclk) disable iff (!rrstn_sync)
        sel_track == dap_pkg::AP_SEL_APB |-> ap_rsp.busy == apb_m.psel)
        else fault("ap_rsp.busy does not follow the APB transfer");

    a_unrouted_quiet: assert property (@(posedge wclk) disable iff (!rrstn_sync)
        sel_track == 8'h03 |-> ap_rsp == '0 && !apb_m.psel && !mem_m.valid)
        else fault("unrouted select gave a response or a bus cycle");

    a_mem_busy: assert property (@(posedge wclk) disable iff (!rrstn_sync)
        sel_track == dap_pkg::AP_SEL_MEM && mem_m.valid |-> ap_rsp.busy)
        else fault("memory beat issued while ap_rsp.busy was low");

    initial begin
        int          cycles;
        int          n;
        int          k;
        logic [31:0] tar;
        logic [31:0] data;
        logic [31:0] word;
        wclk         = 1'b0;
        rrstn_sync   = 1'b0;
        ap_upd       = 1'b0;
        ap_req       = '0;
        apb_deviceen = 1'b1;
        mem_deviceen = 1'b1;
        wbuf_push    = 1'b0;
        wbuf_wdata   = '0;
        rbuf_pop     = 1'b0;
        rresp_pop    = 1'b0;
        apb_wait     = '0;
        lfsr         = 32'h8e12705e;
        sel_track    = dap_pkg::AP_SEL_APB;
        resp_wr      = 0;
        errors       = 0;
        err_mark     = 0;
        tests        = 0;
        tests_failed = 0;
        for (int i = 0; i < 64; i++) begin
            resp_exp[i] = dap_pkg::RESP_OKAY;
        end
        repeat (10) @(negedge wclk);
        rrstn_sync = 1'b1;
        @(negedge wclk);

        assert (!apb_m.psel) else mismatch("apb_m.psel", 64'(apb_m.psel), 0);
        assert (!apb_m.penable) else mismatch("apb_m.penable", 64'(apb_m.penable), 0);
        assert (!mem_m.valid) else mismatch("mem_m.valid", 64'(mem_m.valid), 0);
        assert (!ap_rsp.busy) else mismatch("ap_rsp.busy", 64'(ap_rsp.busy), 0);
        assert (rresp_rdata == '0) else mismatch("rresp_rdata", 64'(rresp_rdata), 0);
        end_test("reset state");

        for (int i = 0; i < 3; i++) begin
            tar  = take_bits(32) & 32'h0000_03FC;
            data = take_bits(32);
            update(dap_pkg::AP_SEL_APB, dap_pkg::REG_TAR, 1'b0, tar);
            apb_wait = 2'(take_bits(2) % 3);
            update(dap_pkg::AP_SEL_APB, dap_pkg::REG_DRW, 1'b0, data);
            // setup cycle carries address and write data
            assert (apb_m.paddr == tar)
                else mismatch("apb_m.paddr", 64'(apb_m.paddr), 64'(tar));
            assert (apb_m.pwrite) else mismatch("apb_m.pwrite", 64'(apb_m.pwrite), 1);
            assert (apb_m.pwdata == data)
                else mismatch("apb_m.pwdata", 64'(apb_m.pwdata), 64'(data));
            wait_idle(cycles);
            // setup cycle plus access cycles
            assert (cycles == apb_wait + 2)
                else mismatch("busy cycles", 64'(cycles), 64'(apb_wait + 2));
            assert (!ap_rsp.slverr) else mismatch("ap_rsp.slverr", 64'(ap_rsp.slverr), 0);
            apb_wait = 2'(take_bits(2) % 3);
            update(dap_pkg::AP_SEL_APB, dap_pkg::REG_DRW, 1'b1, '0);
            assert (apb_m.paddr == tar)
                else mismatch("apb_m.paddr", 64'(apb_m.paddr), 64'(tar));
            assert (!apb_m.pwrite) else mismatch("apb_m.pwrite", 64'(apb_m.pwrite), 0);
            wait_idle(cycles);
            assert (ap_rsp.rdata == data)
                else mismatch("ap_rsp.rdata", 64'(ap_rsp.rdata), 64'(data));
            assert (!ap_rsp.slverr) else mismatch("ap_rsp.slverr", 64'(ap_rsp.slverr), 0);
            update(dap_pkg::AP_SEL_APB, dap_pkg::REG_TAR, 1'b1, '0);
            assert (ap_rsp.rdata == tar)
                else mismatch("ap_rsp.rdata", 64'(ap_rsp.rdata), 64'(tar));
            assert (!ap_rsp.busy) else mismatch("ap_rsp.busy", 64'(ap_rsp.busy), 0);
        end
        end_test("apb access");

        tar = dap_pkg::ERR_BASE | (take_bits(16) & 32'h0000_FFFC);
        update(dap_pkg::AP_SEL_APB, dap_pkg::REG_TAR, 1'b0, tar);
        update(dap_pkg::AP_SEL_APB, dap_pkg::REG_DRW, 1'b0, take_bits(32));
        wait_idle(cycles);
        assert (ap_rsp.slverr) else mismatch("ap_rsp.slverr", 64'(ap_rsp.slverr), 1);
        update(dap_pkg::AP_SEL_APB, dap_pkg::REG_DRW, 1'b1, '0);
        wait_idle(cycles);
        assert (ap_rsp.slverr) else mismatch("ap_rsp.slverr", 64'(ap_rsp.slverr), 1);
        update(dap_pkg::AP_SEL_APB, dap_pkg::REG_TAR, 1'b0, 32'h0000_0040);
        update(dap_pkg::AP_SEL_APB, dap_pkg::REG_DRW, 1'b0, take_bits(32));
        wait_idle(cycles);
        assert (!ap_rsp.slverr) else mismatch("ap_rsp.slverr", 64'(ap_rsp.slverr), 0);
        apb_deviceen = 1'b0;
        update(dap_pkg::AP_SEL_APB, dap_pkg::REG_DRW, 1'b0, take_bits(32));
        assert (ap_rsp.slverr) else mismatch("ap_rsp.slverr", 64'(ap_rsp.slverr), 1);
        wait_idle(cycles);
        assert (cycles == 0) else mismatch("busy cycles", 64'(cycles), 0);
        repeat (3) @(negedge wclk);
        apb_deviceen = 1'b1;
        end_test("apb errors");

        for (int r = 0; r < 3; r++) begin
            n   = int'(take_bits(5) % 20) + 1;
            tar = take_bits(32) & 32'h0000_0FFC;
            for (int i = 0; i < n; i++) begin
                word = take_bits(32);
                exp_words.push_back(word);
                wbuf_push  = 1'b1;
                wbuf_wdata = word;
                @(negedge wclk);
            end
            wbuf_push = 1'b0;
            burst(dap_pkg::REG_BWR, n, tar);
            assert (!ap_rsp.slverr) else mismatch("ap_rsp.slverr", 64'(ap_rsp.slverr), 0);
            burst(dap_pkg::REG_BRD, n, tar);
            assert (!ap_rsp.slverr) else mismatch("ap_rsp.slverr", 64'(ap_rsp.slverr), 0);
            drain_reads(n, 1'b1);
        end
        end_test("burst round trip");

        k   = int'(take_bits(3)) + 1;
        n   = k + int'(take_bits(3)) + 1;
        tar = dap_pkg::ERR_BASE - 32'(4 * k);
        burst(dap_pkg::REG_BRD, n, tar);
        assert (ap_rsp.slverr) else mismatch("ap_rsp.slverr", 64'(ap_rsp.slverr), 1);
        drain_reads(n, 1'b0);
        // device disabled, every beat answers slverr and reads as zero
        mem_deviceen = 1'b0;
        n = int'(take_bits(2)) + 1;
        for (int i = 0; i < n; i++) begin
            exp_words.push_back(32'h0);
        end
        burst(dap_pkg::REG_BRD, n, 32'h0000_0200);
        mem_deviceen = 1'b1;
        assert (ap_rsp.slverr) else mismatch("ap_rsp.slverr", 64'(ap_rsp.slverr), 1);
        drain_reads(n, 1'b1);
        // all four packed words, beat k at word k/16 field k%16
        for (int w = 0; w < 4; w++) begin
            word = '0;
            for (int f = 0; f < 16; f++) begin
                word[2*f +: 2] = resp_exp[16*w + f];
            end
            assert (rresp_rdata == word) else mismatch("rresp_rdata", 64'(rresp_rdata), 64'(word));
            rresp_pop = 1'b1;
            @(negedge wclk);
        end
        rresp_pop = 1'b0;
        end_test("response packing");

        // neither a transfer nor a burst may start
        update(8'h03, dap_pkg::REG_DRW, 1'b0, take_bits(32));
        update(8'h03, dap_pkg::REG_BRD, 1'b0, 32'd4);
        for (int i = 0; i < 6; i++) begin
            assert (ap_rsp == '0) else mismatch("ap_rsp", 64'(ap_rsp), 0);
            @(negedge wclk);
        end
        n = int'(take_bits(3)) + 2;
        burst(dap_pkg::REG_BRD, n, 32'h0000_0100);
        drain_reads(n, 1'b0);
        end_test("routing");

        $display("tests run: %0d, tests failed: %0d, errors: %0d", tests, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* tb/tb_slaves.sv */
`timescale 1ns/100ps

// APB slave with a programmable number of wait states
module apb_slave_model (
    input  logic              wclk,
    input  logic              rrstn_sync,
    input  logic [1:0]        wait_cycles,
    input  dap_pkg::apb_req_t req,
    output dap_pkg::apb_rsp_t rsp
);

    logic [31:0] mem [256];
    logic [1:0]  cnt;
    logic        err;

    assign err         = req.paddr >= dap_pkg::ERR_BASE;
    assign rsp.pready  = req.psel && req.penable && cnt == wait_cycles;
    assign rsp.prdata  = mem[req.paddr[9:2]];
    assign rsp.pslverr = rsp.pready && err;

    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = 32'(i) * 32'h9E37_79B9;
        end
    end

    always_ff @(posedge wclk or negedge rrstn_sync) begin
        if (!rrstn_sync) begin
            cnt <= '0;
        end else if (rsp.pready || !req.penable) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 2'd1;
        end
    end

    always @(posedge wclk) begin
        if (rsp.pready && req.pwrite && !err) begin
            mem[req.paddr[9:2]] <= req.pwdata;
        end
    end

endmodule

// memory answering every beat one cycle later
module mem_model (
    input  logic              wclk,
    input  logic              rrstn_sync,
    input  dap_pkg::mem_req_t req,
    output dap_pkg::mem_rsp_t rsp
);

    logic [31:0] mem [256];

    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = 32'(i) * 32'h85EB_CA6B;
        end
    end

    always_ff @(posedge wclk or negedge rrstn_sync) begin
        if (!rrstn_sync) begin
            rsp <= '0;
        end else begin
            rsp.rvalid <= req.valid;
            rsp.err    <= req.valid && req.addr >= dap_pkg::ERR_BASE;
            rsp.rdata  <= mem[req.addr[9:2]];
        end
    end

    always @(posedge wclk) begin
        if (req.valid && req.we && req.addr < dap_pkg::ERR_BASE) begin
            mem[req.addr[9:2]] <= req.wdata;
        end
    end

endmodule
